/* mips_pkg.sv */
`default_nettype none

package mips_pkg;

    localparam int XLEN           = 32;
    localparam int REG_AW         = 5;
    localparam int NUM_REGS       = 32;
    localparam int BYTES_PER_WORD = 4;

    //////////////////////////////////////////////////////////////////////
    // Opcode and function fields

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LB      = 6'h20;
    localparam logic [5:0] OP_LH      = 6'h21;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_LBU     = 6'h24;
    localparam logic [5:0] OP_LHU     = 6'h25;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SH      = 6'h29;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam logic [XLEN-1:0] NOP_INSTR = '0; // sll r0, r0, 0

    // Operand select codes from the hazard unit
    localparam logic [1:0] FWD_REG   = 2'd0;
    localparam logic [1:0] FWD_EXMEM = 2'd1;
    localparam logic [1:0] FWD_MEMWB = 2'd2;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_BYTE, MEM_HALF, MEM_WORD
    } mem_size_e;

    //////////////////////////////////////////////////////////////////////
    // Stage payloads

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   rs_val;
        logic [XLEN-1:0]   rt_val;
        logic [XLEN-1:0]   imm;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] rd;
        alu_op_e           alu_op;
        logic              alu_src_imm;
        logic              reg_write;
        logic              load;
        logic              store;
        logic              load_unsigned;
        mem_size_e         mem_size;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   alu_result;
        logic [XLEN-1:0]   store_data;
        logic [REG_AW-1:0] rd;
        logic              reg_write;
        logic              load;
        logic              store;
        logic              load_unsigned;
        mem_size_e         mem_size;
    } ex_mem_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   value;
        logic [REG_AW-1:0] rd;
        logic              reg_write;
    } mem_wb_t;

endpackage

`default_nettype wire

/* pipe_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic hold_i,   // Stall, keep contents
    input  wire logic bubble_i, // Load an empty slot
    input  payload_t  d_i,
    output payload_t  q_o
);

    // An all-zero payload has every write and store flag off
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            q_o <= payload_t'('0);
        end else if (hold_i) begin
            q_o <= q_o;
        end else if (bubble_i) begin
            q_o <= payload_t'('0);
        end else begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

/* inst_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_decode import mips_pkg::*; (
    input  wire logic [XLEN-1:0]   instr_i,
    output logic      [REG_AW-1:0] rs_o,
    output logic      [REG_AW-1:0] rt_o,
    output logic      [REG_AW-1:0] rd_o,
    output logic                   uses_rt_o,
    output logic      [XLEN-1:0]   imm_o,
    output alu_op_e                alu_op_o,
    output logic                   alu_src_imm_o,
    output logic                   reg_write_o,
    output logic                   load_o,
    output logic                   store_o,
    output logic                   unsigned_o,
    output mem_size_e              mem_size_o
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];
    assign imm16  = instr_i[15:0];
    assign rs_o   = instr_i[25:21];
    assign rt_o   = instr_i[20:16];

    always_comb begin
        rd_o          = instr_i[20:16];      // I-type writes rt
        uses_rt_o     = 1'b0;
        imm_o         = {{16{imm16[15]}}, imm16};
        alu_op_o      = ALU_ADD;
        alu_src_imm_o = 1'b1;
        reg_write_o   = 1'b0;
        load_o        = 1'b0;
        store_o       = 1'b0;
        unsigned_o    = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                rd_o          = instr_i[15:11];
                uses_rt_o     = 1'b1;
                alu_src_imm_o = 1'b0;
                reg_write_o   = 1'b1;
                case (funct)
                    FN_ADDU: alu_op_o = ALU_ADD;
                    FN_SUBU: alu_op_o = ALU_SUB;
                    FN_AND:  alu_op_o = ALU_AND;
                    FN_OR:   alu_op_o = ALU_OR;
                    FN_XOR:  alu_op_o = ALU_XOR;
                    FN_SLT:  alu_op_o = ALU_SLT;
                    default: reg_write_o = 1'b0; // Shifts etc. become no-ops
                endcase
            end
            OP_ADDIU: reg_write_o = 1'b1;
            OP_ORI: begin
                reg_write_o = 1'b1;
                alu_op_o    = ALU_OR;
                imm_o       = {16'b0, imm16};
            end
            OP_LUI: begin
                reg_write_o = 1'b1;
                alu_op_o    = ALU_PASS_B;
                imm_o       = {imm16, 16'b0};
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                reg_write_o = 1'b1;
                load_o      = 1'b1;
                unsigned_o  = (opcode == OP_LBU) || (opcode == OP_LHU);
            end
            OP_SB, OP_SH, OP_SW: begin
                uses_rt_o = 1'b1;                // Store data
                store_o   = 1'b1;
            end
            default: ;
        endcase
    end

    // Access size sits in the low opcode bits of every load and store
    always_comb begin
        case (opcode[1:0])
            2'b00:   mem_size_o = MEM_BYTE;
            2'b01:   mem_size_o = MEM_HALF;
            default: mem_size_o = MEM_WORD;
        endcase
    end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file import mips_pkg::*; (
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    input  wire logic [REG_AW-1:0] ra_i,
    input  wire logic [REG_AW-1:0] rb_i,
    output logic      [XLEN-1:0]   rdata_a_o,
    output logic      [XLEN-1:0]   rdata_b_o,
    input  wire logic              we_i,
    input  wire logic [REG_AW-1:0] waddr_i,
    input  wire logic [XLEN-1:0]   wdata_i
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wr_en;

    assign wr_en = we_i && (waddr_i != '0); // r0 stays zero

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Same-cycle write passes through to decode
    assign rdata_a_o = (wr_en && waddr_i == ra_i) ? wdata_i : regs[ra_i];
    assign rdata_b_o = (wr_en && waddr_i == rb_i) ? wdata_i : regs[rb_i];

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu import mips_pkg::*; (
    input  alu_op_e              op_i,
    input  wire logic [XLEN-1:0] a_i,
    input  wire logic [XLEN-1:0] b_i,
    output logic      [XLEN-1:0] result_o
);

    logic less;

    assign less = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;   // Wraps, no overflow trap
            ALU_SUB:    result_o = a_i - b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_OR:     result_o = a_i | b_i;
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, less};
            ALU_PASS_B: result_o = b_i;         // LUI
            default:    result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* mem_align.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_align import mips_pkg::*; (
    input  mem_size_e                        size_i,
    input  wire logic                        unsigned_i,
    input  wire logic                        store_i,
    input  wire logic [1:0]                  addr_lo_i,
    input  wire logic [XLEN-1:0]             store_data_i,
    input  wire logic [XLEN-1:0]             rdata_i,
    output logic      [XLEN-1:0]             wdata_o,
    output logic      [BYTES_PER_WORD-1:0]   be_o,
    output logic      [XLEN-1:0]             load_data_o
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    //////////////////////////////////////////////////////////////////////
    // Store side

    always_comb begin
        case (size_i)
            MEM_BYTE: begin
                wdata_o = {4{store_data_i[7:0]}};
                be_o    = BYTES_PER_WORD'(1) << addr_lo_i;
            end
            MEM_HALF: begin
                wdata_o = {2{store_data_i[15:0]}};
                be_o    = addr_lo_i[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wdata_o = store_data_i;
                be_o    = 4'b1111;
            end
        endcase
        if (!store_i) begin
            be_o = '0; // Loads never write
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Load side

    assign byte_lane = rdata_i[8*addr_lo_i +: 8];
    assign half_lane = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        case (size_i)
            MEM_BYTE: load_data_o = unsigned_i ? {24'b0, byte_lane}
                                               : {{24{byte_lane[7]}}, byte_lane};
            MEM_HALF: load_data_o = unsigned_i ? {16'b0, half_lane}
                                               : {{16{half_lane[15]}}, half_lane};
            default:  load_data_o = rdata_i;
        endcase
    end

endmodule

`default_nettype wire

/* hazard_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module hazard_unit import mips_pkg::*; (
    // Decode stage sources
    input  wire logic [REG_AW-1:0] id_rs_i,
    input  wire logic [REG_AW-1:0] id_rt_i,
    input  wire logic              id_uses_rt_i,
    // Execute stage
    input  wire logic [REG_AW-1:0] ex_rs_i,
    input  wire logic [REG_AW-1:0] ex_rt_i,
    input  wire logic [REG_AW-1:0] ex_rd_i,
    input  wire logic              ex_reg_write_i,
    input  wire logic              ex_load_i,
    // Memory stage producer
    input  wire logic [REG_AW-1:0] mem_rd_i,
    input  wire logic              mem_reg_write_i,
    input  wire logic              mem_load_i,
    // Writeback producer
    input  wire logic [REG_AW-1:0] wb_rd_i,
    input  wire logic              wb_reg_write_i,
    output logic      [1:0]        fwd_a_o,
    output logic      [1:0]        fwd_b_o,
    output logic                   stall_o
);

    logic ex_load_live;

    // Nearest producer wins; a load in MEM has no data yet
    function automatic logic [1:0] fwd_sel(input logic [REG_AW-1:0] src);
        if (mem_reg_write_i && !mem_load_i && mem_rd_i != '0 && mem_rd_i == src) begin
            return FWD_EXMEM;
        end
        if (wb_reg_write_i && wb_rd_i != '0 && wb_rd_i == src) begin
            return FWD_MEMWB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwd_a_o = fwd_sel(ex_rs_i);
        fwd_b_o = fwd_sel(ex_rt_i);
    end

    //////////////////////////////////////////////////////////////////////
    // Load-use detection

    assign ex_load_live = ex_load_i && ex_reg_write_i && (ex_rd_i != '0);

    // Bubble behind the load clears this on the next cycle
    assign stall_o = ex_load_live &&
                     ((ex_rd_i == id_rs_i) || (id_uses_rt_i && ex_rd_i == id_rt_i));

endmodule

`default_nettype wire

/* mips_core.sv */
`timescale 1ns/100ps
`default_nettype none

module mips_core import mips_pkg::*; (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,
    // Instruction memory
    output logic      [XLEN-1:0]           imem_addr_o,
    input  wire logic [XLEN-1:0]           imem_data_i,
    // Data memory
    output logic      [XLEN-1:0]           dmem_addr_o,
    output logic      [XLEN-1:0]           dmem_wdata_o,
    output logic      [BYTES_PER_WORD-1:0] dmem_be_o,
    output logic                           dmem_we_o,
    input  wire logic [XLEN-1:0]           dmem_rdata_i,
    // Writeback trace
    output logic      [XLEN-1:0]           dbg_wb_pc_o,
    output logic      [3:0]                dbg_wb_rf_wen_o,
    output logic      [REG_AW-1:0]         dbg_wb_rf_wnum_o,
    output logic      [XLEN-1:0]           dbg_wb_rf_wdata_o
);

    logic [XLEN-1:0] pc;
    logic            stall;
    logic [1:0]      fwd_a, fwd_b;

    if_id_t  if_id_d,  if_id_q;
    id_ex_t  id_ex_d,  id_ex_q;
    ex_mem_t ex_mem_d, ex_mem_q;
    mem_wb_t mem_wb_d, mem_wb_q;

    logic            id_uses_rt;
    logic [XLEN-1:0] op_a, op_b_reg, alu_b, alu_result;
    logic [XLEN-1:0] load_data;

    // Operand select shared by both EX inputs
    function automatic logic [XLEN-1:0] fwd_mux(input logic [1:0] sel,
                                                input logic [XLEN-1:0] reg_val);
        case (sel)
            FWD_EXMEM: return ex_mem_q.alu_result;
            FWD_MEMWB: return mem_wb_q.value;
            default:   return reg_val;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Fetch

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc + BYTES_PER_WORD;
        end
    end

    assign imem_addr_o = pc;
    assign if_id_d     = '{pc: pc, instr: imem_data_i};

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .hold_i  (stall),
        .bubble_i(1'b0),
        .d_i     (if_id_d),
        .q_o     (if_id_q)
    );

    //////////////////////////////////////////////////////////////////////
    // Decode

    assign id_ex_d.pc = if_id_q.pc;

    inst_decode u_decode (
        .instr_i      (if_id_q.instr),
        .rs_o         (id_ex_d.rs),
        .rt_o         (id_ex_d.rt),
        .rd_o         (id_ex_d.rd),
        .uses_rt_o    (id_uses_rt),
        .imm_o        (id_ex_d.imm),
        .alu_op_o     (id_ex_d.alu_op),
        .alu_src_imm_o(id_ex_d.alu_src_imm),
        .reg_write_o  (id_ex_d.reg_write),
        .load_o       (id_ex_d.load),
        .store_o      (id_ex_d.store),
        .unsigned_o   (id_ex_d.load_unsigned),
        .mem_size_o   (id_ex_d.mem_size)
    );

    reg_file u_rf (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .ra_i     (id_ex_d.rs),
        .rb_i     (id_ex_d.rt),
        .rdata_a_o(id_ex_d.rs_val),
        .rdata_b_o(id_ex_d.rt_val),
        .we_i     (mem_wb_q.reg_write),
        .waddr_i  (mem_wb_q.rd),
        .wdata_i  (mem_wb_q.value)
    );

    hazard_unit u_hazard (
        .id_rs_i        (id_ex_d.rs),
        .id_rt_i        (id_ex_d.rt),
        .id_uses_rt_i   (id_uses_rt),
        .ex_rs_i        (id_ex_q.rs),
        .ex_rt_i        (id_ex_q.rt),
        .ex_rd_i        (id_ex_q.rd),
        .ex_reg_write_i (id_ex_q.reg_write),
        .ex_load_i      (id_ex_q.load),
        .mem_rd_i       (ex_mem_q.rd),
        .mem_reg_write_i(ex_mem_q.reg_write),
        .mem_load_i     (ex_mem_q.load),
        .wb_rd_i        (mem_wb_q.rd),
        .wb_reg_write_i (mem_wb_q.reg_write),
        .fwd_a_o        (fwd_a),
        .fwd_b_o        (fwd_b),
        .stall_o        (stall)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .hold_i  (1'b0),
        .bubble_i(stall),   // Load-use gap
        .d_i     (id_ex_d),
        .q_o     (id_ex_q)
    );

    //////////////////////////////////////////////////////////////////////
    // Execute

    always_comb begin
        op_a     = fwd_mux(fwd_a, id_ex_q.rs_val);
        op_b_reg = fwd_mux(fwd_b, id_ex_q.rt_val);  // Also the store data
    end

    assign alu_b = id_ex_q.alu_src_imm ? id_ex_q.imm : op_b_reg;

    alu u_alu (
        .op_i    (id_ex_q.alu_op),
        .a_i     (op_a),
        .b_i     (alu_b),
        .result_o(alu_result)
    );

    assign ex_mem_d = '{
        pc:            id_ex_q.pc,
        alu_result:    alu_result,
        store_data:    op_b_reg,
        rd:            id_ex_q.rd,
        reg_write:     id_ex_q.reg_write,
        load:          id_ex_q.load,
        store:         id_ex_q.store,
        load_unsigned: id_ex_q.load_unsigned,
        mem_size:      id_ex_q.mem_size
    };

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .hold_i  (1'b0),
        .bubble_i(1'b0),
        .d_i     (ex_mem_d),
        .q_o     (ex_mem_q)
    );

    //////////////////////////////////////////////////////////////////////
    // Memory and writeback

    assign dmem_addr_o = ex_mem_q.alu_result;
    assign dmem_we_o   = ex_mem_q.store;

    mem_align u_align (
        .size_i      (ex_mem_q.mem_size),
        .unsigned_i  (ex_mem_q.load_unsigned),
        .store_i     (ex_mem_q.store),
        .addr_lo_i   (ex_mem_q.alu_result[1:0]),
        .store_data_i(ex_mem_q.store_data),
        .rdata_i     (dmem_rdata_i),
        .wdata_o     (dmem_wdata_o),
        .be_o        (dmem_be_o),
        .load_data_o (load_data)
    );

    assign mem_wb_d = '{
        pc:        ex_mem_q.pc,
        value:     ex_mem_q.load ? load_data : ex_mem_q.alu_result,
        rd:        ex_mem_q.rd,
        reg_write: ex_mem_q.reg_write
    };

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .hold_i  (1'b0),
        .bubble_i(1'b0),
        .d_i     (mem_wb_d),
        .q_o     (mem_wb_q)
    );

    assign dbg_wb_pc_o       = mem_wb_q.pc;
    assign dbg_wb_rf_wen_o   = {4{mem_wb_q.reg_write}};
    assign dbg_wb_rf_wnum_o  = mem_wb_q.rd;
    assign dbg_wb_rf_wdata_o = mem_wb_q.value;

endmodule

`default_nettype wire

/* mips_core_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module mips_core_checker import mips_pkg::*; (
    input wire logic                      clk_i,
    input wire logic                      rst_i,
    input wire logic                      dmem_we_i,
    input wire logic [BYTES_PER_WORD-1:0] dmem_be_i,
    input wire logic                      stall_i,
    input wire logic [3:0]                dbg_wen_i
);

    mask_idle_a: assert property (@(posedge clk_i) disable iff (rst_i)
        !dmem_we_i |-> dmem_be_i == '0)
        else $error("Byte mask set while no store is active");

    // Word, half pair or single byte
    mask_legal_a: assert property (@(posedge clk_i) disable iff (rst_i)
        dmem_we_i |-> dmem_be_i inside {4'b1111, 4'b0011, 4'b1100,
                                        4'b0001, 4'b0010, 4'b0100, 4'b1000})
        else $error("Store byte mask is not a legal pattern");

    stall_once_a: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_i |=> !stall_i)  // Bubble clears the load-use case
        else $error("Stall held for two cycles in a row");

    reset_quiet_a: assert property (@(posedge clk_i)
        rst_i |=> dbg_wen_i == '0)
        else $error("Debug write enable active right after reset");

endmodule

bind mips_core mips_core_checker u_checker (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .dmem_we_i(dmem_we_o),
    .dmem_be_i(dmem_be_o),
    .stall_i  (stall),
    .dbg_wen_i(dbg_wb_rf_wen_o)
);

`default_nettype wire

/* tb_mips_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mips_core import mips_pkg::*; ();

    localparam int          PROG_LEN    = 200;
    localparam int          DMEM_WORDS  = 64;
    localparam logic [31:0] SEED        = 32'hbe18_5fcd;
    localparam int          RESET_LIMIT = 20;
    localparam int          DRAIN_LIMIT = 2000;

    logic                      clk_i;
    logic                      rst_i;
    logic [XLEN-1:0]           imem_addr;
    logic [XLEN-1:0]           imem_data;
    logic [XLEN-1:0]           dmem_addr;
    logic [XLEN-1:0]           dmem_wdata;
    logic [BYTES_PER_WORD-1:0] dmem_be;
    logic                      dmem_we;
    logic [XLEN-1:0]           dmem_rdata;
    logic [XLEN-1:0]           wb_pc;
    logic [3:0]                wb_wen;
    logic [REG_AW-1:0]         wb_wnum;
    logic [XLEN-1:0]           wb_wdata;

    logic [XLEN-1:0] prog [PROG_LEN];
    logic [XLEN-1:0] dmem [DMEM_WORDS];

    // Reference model state with memory kept as bytes
    logic [XLEN-1:0] model_regs  [NUM_REGS];
    logic [7:0]      model_bytes [DMEM_WORDS*BYTES_PER_WORD];

    // Expected events with the oldest first
    logic [XLEN-1:0]   exp_wr_pc   [$];
    logic [REG_AW-1:0] exp_wr_reg  [$];
    logic [XLEN-1:0]   exp_wr_val  [$];
    logic [XLEN-1:0]   exp_st_addr [$];
    logic [3:0]        exp_st_be   [$];
    logic [XLEN-1:0]   exp_st_data [$];

    mips_core u_dut (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .imem_addr_o      (imem_addr),
        .imem_data_i      (imem_data),
        .dmem_addr_o      (dmem_addr),
        .dmem_wdata_o     (dmem_wdata),
        .dmem_be_o        (dmem_be),
        .dmem_we_o        (dmem_we),
        .dmem_rdata_i     (dmem_rdata),
        .dbg_wb_pc_o      (wb_pc),
        .dbg_wb_rf_wen_o  (wb_wen),
        .dbg_wb_rf_wnum_o (wb_wnum),
        .dbg_wb_rf_wdata_o(wb_wdata)
    );

    always #50 clk_i = ~clk_i;

    initial begin
        clk_i = 1'b0;
        rst_i = 1'b1;
        repeat (4) @(posedge clk_i);
        #1 rst_i = 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // Memories

    assign imem_data  = (imem_addr[XLEN-1:2] < PROG_LEN) ? prog[imem_addr[9:2]] : NOP_INSTR;
    assign dmem_rdata = dmem[dmem_addr[7:2]];  // Combinational read

    always @(posedge clk_i) begin
        if (dmem_we) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (dmem_be[b]) dmem[dmem_addr[7:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
            end
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at the first error");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Random program and reference model

    function automatic logic [XLEN-1:0] random_instr();
        logic [4:0]  rs, rt, rd;
        logic [15:0] word_off, half_off, byte_off;
        int unsigned kind;
        rs       = 5'($urandom_range(0, 7));  // Few registers give many dependencies
        rt       = 5'($urandom_range(0, 7));
        rd       = 5'($urandom_range(0, 7));
        kind     = $urandom_range(0, 16);
        word_off = 16'($urandom_range(0, DMEM_WORDS - 1) * 4);
        half_off = word_off | 16'(2 * $urandom_range(0, 1));
        byte_off = word_off | 16'($urandom_range(0, 3));
        case (kind)
            0:       return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_ADDU};
            1:       return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SUBU};
            2:       return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_AND};
            3:       return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_OR};
            4:       return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_XOR};
            5:       return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SLT};
            6:       return {OP_ADDIU, rs, rt, 16'($urandom)};
            7:       return {OP_ORI, rs, rt, 16'($urandom)};
            8:       return {OP_LUI, 5'd0, rt, 16'($urandom)};
            9:       return {OP_LW, 5'd0, rt, word_off};   // Base is always r0
            10:      return {OP_LH, 5'd0, rt, half_off};
            11:      return {OP_LHU, 5'd0, rt, half_off};
            12:      return {OP_LB, 5'd0, rt, byte_off};
            13:      return {OP_LBU, 5'd0, rt, byte_off};
            14:      return {OP_SW, 5'd0, rt, word_off};
            15:      return {OP_SH, 5'd0, rt, half_off};
            default: return {OP_SB, 5'd0, rt, byte_off};
        endcase
    endfunction

    // Little-endian read of the model memory with zero extension
    function automatic logic [XLEN-1:0] read_le(input logic [7:0] addr, input int nbytes);
        logic [XLEN-1:0] val;
        val = '0;
        for (int i = nbytes - 1; i >= 0; i--) begin
            val = (val << 8) | XLEN'(model_bytes[8'(addr + i)]);
        end
        return val;
    endfunction

    task automatic run_model(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] instr);
        logic [5:0]      op;
        logic [XLEN-1:0] a, b, simm, addr, result, lv1, lv2, sdata;
        logic [4:0]      dest;
        logic [3:0]      mask;
        logic            writes;
        int              nbytes;
        op     = instr[31:26];
        a      = model_regs[instr[25:21]];
        b      = model_regs[instr[20:16]];
        simm   = {{16{instr[15]}}, instr[15:0]};
        addr   = a + simm;
        dest   = instr[20:16];
        writes = 1'b1;
        result = '0;
        lv1    = read_le(addr[7:0], 1);
        lv2    = read_le(addr[7:0], 2);
        case (op)
            OP_SPECIAL: begin
                dest = instr[15:11];
                case (instr[5:0])
                    FN_ADDU: result = a + b;
                    FN_SUBU: result = a - b;
                    FN_AND:  result = a & b;
                    FN_OR:   result = a | b;
                    FN_XOR:  result = a ^ b;
                    FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: writes = 1'b0;
                endcase
            end
            OP_ADDIU: result = a + simm;
            OP_ORI:   result = a | {16'h0, instr[15:0]};
            OP_LUI:   result = {instr[15:0], 16'h0};
            OP_LB:    result = {{24{lv1[7]}}, lv1[7:0]};
            OP_LBU:   result = lv1;
            OP_LH:    result = {{16{lv2[15]}}, lv2[15:0]};
            OP_LHU:   result = lv2;
            OP_LW:    result = read_le(addr[7:0], 4);
            OP_SB, OP_SH, OP_SW: begin
                writes = 1'b0;
                nbytes = (op == OP_SB) ? 1 : (op == OP_SH) ? 2 : 4;
                mask   = 4'((1 << nbytes) - 1) << addr[1:0];
                sdata  = (op == OP_SB) ? {4{b[7:0]}} : (op == OP_SH) ? {2{b[15:0]}} : b;
                for (int i = 0; i < nbytes; i++) begin
                    model_bytes[8'(addr[7:0] + i)] = b[8*i +: 8];
                end
                exp_st_addr.push_back(addr);
                exp_st_be.push_back(mask);
                exp_st_data.push_back(sdata);
            end
            default: writes = 1'b0;
        endcase
        if (writes && dest != '0) begin
            model_regs[dest] = result;
            exp_wr_pc.push_back(pc);
            exp_wr_reg.push_back(dest);
            exp_wr_val.push_back(result);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks sampled mid-cycle

    task automatic check_writeback();
        assert (exp_wr_pc.size() > 0)
            else stop_on_error($sformatf("Unexpected write to r%0d at %0t", wb_wnum, $time));
        assert (wb_pc == exp_wr_pc[0] && wb_wnum == exp_wr_reg[0] && wb_wdata == exp_wr_val[0])
            else stop_on_error($sformatf(
                "Mismatch at %0t: writeback pc %h r%0d = %h, expected pc %h r%0d = %h",
                $time, wb_pc, wb_wnum, wb_wdata, exp_wr_pc[0], exp_wr_reg[0], exp_wr_val[0]));
        void'(exp_wr_pc.pop_front());
        void'(exp_wr_reg.pop_front());
        void'(exp_wr_val.pop_front());
    endtask

    task automatic check_store();
        assert (exp_st_addr.size() > 0)
            else stop_on_error($sformatf("Unexpected store to %h at %0t", dmem_addr, $time));
        assert (dmem_addr == exp_st_addr[0] && dmem_be == exp_st_be[0]
                && dmem_wdata == exp_st_data[0])
            else stop_on_error($sformatf(
                "Mismatch at %0t: store %h mask %b data %h, expected %h mask %b data %h",
                $time, dmem_addr, dmem_be, dmem_wdata,
                exp_st_addr[0], exp_st_be[0], exp_st_data[0]));
        void'(exp_st_addr.pop_front());
        void'(exp_st_be.pop_front());
        void'(exp_st_data.pop_front());
    endtask

    always @(negedge clk_i) begin
        if (!rst_i) begin
            // Write enable is either all ones or all zeros
            assert (wb_wen == 4'b0000 || wb_wen == 4'b1111)
                else stop_on_error($sformatf(
                    "Mismatch at %0t: writeback enable %b, expected 0000 or 1111",
                    $time, wb_wen));
            if (wb_wen != '0 && wb_wnum != '0) check_writeback();  // r0 writes are dropped
            if (dmem_we) check_store();
        end
    end

    initial begin
        int unsigned     cycles;
        logic [XLEN-1:0] fill;
        void'($urandom(SEED));
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            fill    = (i * 32'h0204_0811) ^ 32'h5a3c_96e1;
            dmem[i] = fill;
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                model_bytes[4*i + b] = fill[8*b +: 8];
            end
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = random_instr();
            run_model(32'(4 * i), prog[i]);
        end

        cycles = 0;
        while (rst_i !== 1'b0 && cycles < RESET_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        assert (rst_i === 1'b0) else stop_on_error("Reset was never released");

        cycles = 0;
        while ((exp_wr_pc.size() != 0 || exp_st_addr.size() != 0) && cycles < DRAIN_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        #1;  // Last store lands at this edge

        if (exp_wr_pc.size() == 0 && exp_st_addr.size() == 0) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                assert (dmem[i] == read_le(8'(4 * i), 4))
                    else stop_on_error($sformatf("Mismatch at %0t: dmem[%0d] = %h, expected %h",
                                                 $time, i, dmem[i], read_le(8'(4 * i), 4)));
            end
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_on_error($sformatf("Timeout: %0d writes and %0d stores never arrived",
                                    exp_wr_pc.size(), exp_st_addr.size()));
        end
    end

endmodule

`default_nettype wire

/* all.f */
mips_pkg.sv
pipe_reg.sv
inst_decode.sv
reg_file.sv
alu.sv
mem_align.sv
hazard_unit.sv
mips_core.sv
mips_core_checker.sv
tb_mips_core.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - mips_pkg.sv
  - pipe_reg.sv
  - inst_decode.sv
  - reg_file.sv
  - alu.sv
  - mem_align.sv
  - hazard_unit.sv
  - mips_core.sv
  - target: test
    files:
      - mips_core_checker.sv
      - tb_mips_core.sv
